// ==== Makefile ====
SIM      := verilator
TOP      := div_unit_tb
FILELIST := div_unit.f
FLAGS    := --binary --timing --assert
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) hdl/div_unit_consts.svh

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== div_unit.f ====
+incdir+hdl
hdl/div_if_pkg.sv
hdl/div_core_pkg.sv
hdl/div_req_fifo.sv
hdl/div_operand_prep.sv
hdl/div_subshift.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
test/div_unit_asserts.sv
test/div_unit_tb.sv

// ==== hdl/div_core_pkg.sv ====
`include "div_unit_consts.svh"

package div_core_pkg;

   typedef struct packed {
      logic [`DIV_W-1:0] dividend; // Magnitude of the dividend.
      logic [`DIV_W-1:0] divisor;  // Magnitude of the divisor.
   } div_operands_t;

   // Everything the output stage needs to turn raw results into a response.
   typedef struct packed {
      logic [`DIV_TAG_W-1:0] tag;
      logic                  want_rem;
      logic                  q_neg;       // Negate the quotient.
      logic                  r_neg;       // Negate the remainder.
      logic                  div_by_zero;
   } div_fixup_t;

endpackage

// ==== hdl/div_if_pkg.sv ====
`include "div_unit_consts.svh"

package div_if_pkg;

   // Bit 0 marks a signed operation, bit 1 selects the remainder.
   typedef enum logic [1:0] {
      DIVU = 2'b00,
      DIV  = 2'b01,
      REMU = 2'b10,
      REM  = 2'b11
   } div_op_e;

   typedef struct packed {
      logic [`DIV_TAG_W-1:0] tag;
      div_op_e               op;
      logic [`DIV_W-1:0]     dividend;
      logic [`DIV_W-1:0]     divisor;
   } div_req_t;

   typedef struct packed {
      logic [`DIV_TAG_W-1:0] tag;
      logic [`DIV_W-1:0]     result;      // Quotient or remainder, as the op asked.
      logic                  div_by_zero;
   } div_resp_t;

endpackage

// ==== hdl/div_operand_prep.sv ====
`timescale 1ns/1ns
`include "div_unit_consts.svh"

module div_operand_prep (
   input  div_if_pkg::div_req_t       req_i,
   output div_core_pkg::div_operands_t operands_o,
   output div_core_pkg::div_fixup_t    fixup_o
);
   logic is_signed;
   logic a_neg;
   logic b_neg;
   logic zero_div;

   assign is_signed = (req_i.op == div_if_pkg::DIV) || (req_i.op == div_if_pkg::REM);
   assign a_neg     = is_signed && req_i.dividend[`DIV_W-1];
   assign b_neg     = is_signed && req_i.divisor[`DIV_W-1];
   assign zero_div  = (req_i.divisor == '0);

   always_comb begin
      operands_o.dividend = a_neg ? -req_i.dividend : req_i.dividend;
      operands_o.divisor  = b_neg ? -req_i.divisor : req_i.divisor;

      fixup_o.tag         = req_i.tag;
      fixup_o.want_rem    = (req_i.op == div_if_pkg::REMU) || (req_i.op == div_if_pkg::REM);
      fixup_o.q_neg       = (a_neg ^ b_neg) && !zero_div; // Keeps the all-ones quotient.
      fixup_o.r_neg       = a_neg;                        // Remainder follows the dividend.
      fixup_o.div_by_zero = zero_div;
   end

endmodule

// ==== hdl/div_req_fifo.sv ====
`timescale 1ns/1ns
`include "div_unit_consts.svh"

module div_req_fifo (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 wr_valid_i,
   input  div_if_pkg::div_req_t wr_req_i,
   input  logic                 pop_i,
   output logic                 head_valid_o,
   output div_if_pkg::div_req_t head_o,
   output logic                 credit_o
);
   localparam int DEPTH = `DIV_QUEUE_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   div_if_pkg::div_req_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             pop_fire;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign head_valid_o = (count != '0);
   assign head_o       = mem[rd_ptr];
   assign pop_fire     = pop_i && head_valid_o;

   always_ff @(posedge clk_i) begin
      if (wr_valid_i) begin
         mem[wr_ptr] <= wr_req_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end else begin
         if (wr_valid_i) wr_ptr <= ptr_inc(wr_ptr);
         if (pop_fire) rd_ptr <= ptr_inc(rd_ptr);
         case ({wr_valid_i, pop_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         credit_o <= pop_fire; // One credit back per freed entry.
      end
   end

endmodule

// ==== hdl/div_result_fix.sv ====
`timescale 1ns/1ns
`include "div_unit_consts.svh"

module div_result_fix (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     result_valid_i,
   input  logic [`DIV_W-1:0]        quotient_i,
   input  logic [`DIV_W-1:0]        remainder_i,
   input  div_core_pkg::div_fixup_t fixup_i,
   input  logic                     resp_credit_i,
   output logic                     slot_free_o,
   output logic                     resp_valid_o,
   output div_if_pkg::div_resp_t    resp_o
);
   localparam int CRED_W = $clog2(`DIV_RESP_CREDITS + 1);

   logic [CRED_W-1:0] credit_cnt;
   logic [`DIV_W-1:0] q_fix;
   logic [`DIV_W-1:0] r_fix;
   logic [`DIV_W-1:0] result;

   assign q_fix  = fixup_i.q_neg ? -quotient_i : quotient_i;
   assign r_fix  = fixup_i.r_neg ? -remainder_i : remainder_i;
   assign result = fixup_i.want_rem ? r_fix : q_fix;

   assign slot_free_o = (credit_cnt != '0);

   always_ff @(posedge clk_i) begin
      if (result_valid_i) begin
         resp_o.tag         <= fixup_i.tag;
         resp_o.result      <= result;
         resp_o.div_by_zero <= fixup_i.div_by_zero;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         resp_valid_o <= 1'b0;
         credit_cnt   <= CRED_W'(`DIV_RESP_CREDITS);
      end else begin
         resp_valid_o <= result_valid_i;
         case ({resp_credit_i, result_valid_i})
            2'b10:   credit_cnt <= credit_cnt + 1'b1;
            2'b01:   credit_cnt <= credit_cnt - 1'b1; // The response takes its credit.
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

endmodule

// ==== hdl/div_subshift.sv ====
`timescale 1ns/1ns
`include "div_unit_consts.svh"

module div_subshift (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        req_valid_i,
   input  logic                        slot_free_i,
   input  div_core_pkg::div_operands_t operands_i,
   input  div_core_pkg::div_fixup_t    fixup_i,
   output logic                        accept_o,
   output logic                        result_valid_o,
   output logic [`DIV_W-1:0]           quotient_o,
   output logic [`DIV_W-1:0]           remainder_o,
   output div_core_pkg::div_fixup_t    fixup_o
);
   localparam int DQR_W = 2 * `DIV_W + 1;
   localparam int PC_W  = $clog2(`DIV_W + 2);
   localparam logic [PC_W-1:0] PC_LAST = PC_W'(`DIV_W + 1);

   logic [PC_W-1:0]          pcnt;       // Program counter, zero when idle.
   logic [DQR_W-1:0]         dqr;        // Partial remainder above the quotient bits.
   logic [`DIV_W-1:0]        divisor_q;
   div_core_pkg::div_fixup_t fixup_q;
   logic [`DIV_W:0]          partial;
   logic [`DIV_W+1:0]        diff;
   logic                     stepping;

   assign partial  = dqr[DQR_W-2 -: `DIV_W+1];
   assign diff     = {1'b0, partial} - {2'b00, divisor_q};
   assign stepping = (pcnt != '0) && (pcnt != PC_LAST);

   assign accept_o       = (pcnt == '0) && req_valid_i && slot_free_i;
   assign result_valid_o = (pcnt == PC_LAST);
   assign quotient_o     = dqr[`DIV_W-1:0];
   assign remainder_o    = dqr[DQR_W-2 -: `DIV_W];
   assign fixup_o        = fixup_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pcnt <= '0;
      end else if (accept_o) begin
         pcnt <= PC_W'(1);
      end else if (result_valid_o) begin
         pcnt <= '0; // Back to idle after the result cycle.
      end else if (stepping) begin
         pcnt <= pcnt + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept_o) begin
         divisor_q <= operands_i.divisor;
         dqr       <= {{(`DIV_W+1){1'b0}}, operands_i.dividend};
         fixup_q   <= fixup_i;
      end else if (stepping) begin
         if (!diff[`DIV_W+1]) begin
            dqr <= {diff[`DIV_W:0], dqr[`DIV_W-2:0], 1'b1}; // Subtract fits, quotient bit set.
         end else begin
            dqr <= {1'b0, dqr[DQR_W-3:0], 1'b0};
         end
      end
   end

endmodule

// ==== hdl/div_unit.sv ====
`timescale 1ns/1ns
`include "div_unit_consts.svh"

module div_unit (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  req_valid_i,
   input  div_if_pkg::div_req_t  req_i,
   input  logic                  resp_credit_i,
   output logic                  req_credit_o,
   output logic                  resp_valid_o,
   output div_if_pkg::div_resp_t resp_o
);
   logic                        head_valid;
   div_if_pkg::div_req_t        head;
   div_core_pkg::div_operands_t operands;
   div_core_pkg::div_fixup_t    prep_fixup;
   div_core_pkg::div_fixup_t    core_fixup;
   logic                        accept;
   logic                        slot_free;
   logic                        result_valid;
   logic [`DIV_W-1:0]           quotient;
   logic [`DIV_W-1:0]           remainder;

   div_req_fifo fifo0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .wr_valid_i  (req_valid_i),
      .wr_req_i    (req_i),
      .pop_i       (accept),
      .head_valid_o(head_valid),
      .head_o      (head),
      .credit_o    (req_credit_o)
   );

   div_operand_prep prep0 (
      .req_i     (head),
      .operands_o(operands),
      .fixup_o   (prep_fixup)
   );

   div_subshift core0 (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_valid_i   (head_valid),
      .slot_free_i   (slot_free),
      .operands_i    (operands),
      .fixup_i       (prep_fixup),
      .accept_o      (accept),
      .result_valid_o(result_valid),
      .quotient_o    (quotient),
      .remainder_o   (remainder),
      .fixup_o       (core_fixup)
   );

   div_result_fix fix0 (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .result_valid_i(result_valid),
      .quotient_i    (quotient),
      .remainder_i   (remainder),
      .fixup_i       (core_fixup),
      .resp_credit_i (resp_credit_i),
      .slot_free_o   (slot_free),
      .resp_valid_o  (resp_valid_o),
      .resp_o        (resp_o)
   );

endmodule

// ==== hdl/div_unit_consts.svh ====
`ifndef DIV_UNIT_CONSTS_SVH
`define DIV_UNIT_CONSTS_SVH

// Operand, quotient and remainder width.
`define DIV_W 32

`define DIV_TAG_W 4

// Queue entries, which is also the requester's credit count after reset.
`define DIV_QUEUE_DEPTH 4

`define DIV_RESP_CREDITS 2 // Response credits the unit owns after reset.

`endif

// ==== test/div_unit_asserts.sv ====
`timescale 1ns/1ns
`include "div_unit_consts.svh"

module div_unit_asserts (
   input logic clk_i,
   input logic rst_n_i,
   input logic req_valid_i,
   input logic req_credit_i,
   input logic resp_valid_i,
   input logic resp_credit_i,
   input logic head_valid_i,
   input logic accept_i,
   input logic slot_free_i,
   input logic result_valid_i
);
   int queue_fill;
   int resp_credits;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         queue_fill   <= 0;
         resp_credits <= `DIV_RESP_CREDITS;
      end else begin
         queue_fill   <= queue_fill + int'(req_valid_i) - int'(accept_i);
         resp_credits <= resp_credits + int'(resp_credit_i) - int'(resp_valid_i);
      end
   end

   reset_idle: assert property (@(posedge clk_i) !rst_n_i |=>
      !req_credit_i && !resp_valid_i && !accept_i && !result_valid_i && !head_valid_i)
      else $error("Unit is not idle after reset");

   no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i |-> queue_fill < `DIV_QUEUE_DEPTH)
      else $error("Request written into a full queue");

   resp_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_valid_i |-> resp_credits > 0)
      else $error("Response sent without a credit");

   start_needs_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      accept_i |-> queue_fill > 0 && resp_credits > int'(resp_valid_i))
      else $error("Core started without a request or a free slot");

   // A response on its way out has already taken its credit inside the unit.
   slot_tracks_credits: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slot_free_i == (resp_credits > int'(resp_valid_i)))
      else $error("Free slot flag disagrees with the response credits");

   // The result cycle follows the start by a fixed count.
   result_after_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      accept_i |-> ##(`DIV_W + 1) result_valid_i)
      else $error("Core result did not appear on time");

endmodule

bind div_unit div_unit_asserts div_unit_asserts_i (
   .clk_i         (clk_i),
   .rst_n_i       (rst_n_i),
   .req_valid_i   (req_valid_i),
   .req_credit_i  (req_credit_o),
   .resp_valid_i  (resp_valid_o),
   .resp_credit_i (resp_credit_i),
   .head_valid_i  (head_valid),
   .accept_i      (accept),
   .slot_free_i   (slot_free),
   .result_valid_i(result_valid)
);

// ==== test/div_unit_tb.sv ====
`timescale 1ns/1ns
`include "div_unit_consts.svh"

module div_unit_tb;
   localparam int MAX_VEC   = 64;
   localparam int PERIOD    = 100;
   localparam int MAX_PAUSE = 48;

   logic                  clk;
   logic                  rst_n;
   logic                  req_valid;
   div_if_pkg::div_req_t  req;
   logic                  resp_credit;
   logic                  req_credit;
   logic                  resp_valid;
   div_if_pkg::div_resp_t resp;

   logic [1:0]            vec_op   [MAX_VEC];
   logic [`DIV_W-1:0]     vec_a    [MAX_VEC];
   logic [`DIV_W-1:0]     vec_b    [MAX_VEC];
   logic [`DIV_W-1:0]     vec_res  [MAX_VEC];
   logic                  vec_zero [MAX_VEC];
   div_if_pkg::div_resp_t exp_q    [$];      // Expected responses in request order.
   int                    n_vec, next_vec, sent, regained, resp_count, errors;
   int                    unit_credits, owed, pause;
   logic                  running;
   logic                  loaded;
   integer                seed = 8;

   div_unit div_unit_i (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .req_valid_i  (req_valid),
      .req_i        (req),
      .resp_credit_i(resp_credit),
      .req_credit_o (req_credit),
      .resp_valid_o (resp_valid),
      .resp_o       (resp)
   );

   always #(PERIOD / 2) clk = ~clk;

   task automatic read_vectors();
      int         fd;
      int         n;
      string      line;
      logic [1:0] op;
      logic [`DIV_W-1:0] a, b, r;
      logic       z;
      fd = $fopen("test/div_unit_tests.txt", "r");
      if (fd == 0) begin
         $display("Cannot open test/div_unit_tests.txt");
         return;
      end
      while (!$feof(fd) && n_vec < MAX_VEC) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line[0] != "#") begin
            n = $sscanf(line, "%h %h %h %h %h", op, a, b, r, z);
            if (n == 5) begin
               vec_op[n_vec]   = op;
               vec_a[n_vec]    = a;
               vec_b[n_vec]    = b;
               vec_res[n_vec]  = r;
               vec_zero[n_vec] = z;
               n_vec++;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic check_resp(input div_if_pkg::div_resp_t got,
                             input div_if_pkg::div_resp_t exp, input int idx);
      int bad;
      bad = 0;
      if (got.tag !== exp.tag) begin
         $display("Mismatch resp_o.tag test %0d got %h expected %h", idx, got.tag, exp.tag);
         bad++;
      end
      if (got.result !== exp.result) begin
         $display("Mismatch resp_o.result test %0d got %h expected %h", idx, got.result,
                  exp.result);
         bad++;
      end
      if (got.div_by_zero !== exp.div_by_zero) begin
         $display("Mismatch resp_o.div_by_zero test %0d got %h expected %h", idx,
                  got.div_by_zero, exp.div_by_zero);
         bad++;
      end
      if (bad == 0) $display("Test %0d ok, tag %h result %h", idx, got.tag, got.result);
      errors += bad;
   endtask

   task automatic check_credits(input int got, input int exp);
      if (got != exp) begin
         $display("Mismatch req_credit_o count got %h expected %h", got, exp);
         errors++;
      end else begin
         $display("Request credits ok, %0d regained", got);
      end
   endtask

   // Requester side. Outputs are sampled mid-cycle, inputs change here too.
   always @(negedge clk) begin
      div_if_pkg::div_req_t  r;
      div_if_pkg::div_resp_t e;
      req_valid = 1'b0;
      if (running) begin
         if (req_credit) regained++;
         if (next_vec < n_vec && sent - regained < `DIV_QUEUE_DEPTH) begin
            r.tag      = next_vec[`DIV_TAG_W-1:0];
            r.op       = div_if_pkg::div_op_e'(vec_op[next_vec]);
            r.dividend = vec_a[next_vec];
            r.divisor  = vec_b[next_vec];
            e.tag         = r.tag;
            e.result      = vec_res[next_vec];
            e.div_by_zero = vec_zero[next_vec];
            exp_q.push_back(e);
            req       = r;
            req_valid = 1'b1;
            sent++;
            next_vec++;
         end
      end
   end

   // Consumer side. Credits go back after a random pause, at times longer than a division.
   always @(negedge clk) begin
      resp_credit = 1'b0;
      if (running) begin
         if (resp_valid) begin
            if (unit_credits == 0) begin
               $display("Response %0d arrived while the unit held no credit", resp_count);
               errors++;
            end else begin
               unit_credits--;
            end
            if (exp_q.size() == 0) begin
               $display("Response arrived with no request outstanding");
               errors++;
            end else begin
               check_resp(resp, exp_q.pop_front(), resp_count);
            end
            resp_count++;
            owed++;
         end
         if (owed > 0) begin
            if (pause == 0) begin
               resp_credit = 1'b1;
               owed--;
               unit_credits++;
               pause = {$random(seed)} % MAX_PAUSE;
            end else begin
               pause--;
            end
         end
      end
   end

   initial begin
      wait (loaded);
      #((n_vec * (`DIV_W + 10) + 200) * PERIOD);
      $display("Timeout with %0d of %0d responses received", resp_count, n_vec);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      resp_credit  = 1'b0;
      running      = 1'b0;
      loaded       = 1'b0;
      unit_credits = `DIV_RESP_CREDITS;
      pause        = {$random(seed)} % MAX_PAUSE;
      read_vectors();
      if (n_vec == 0) begin
         $display("No test vectors were read");
         $display("STATUS: FAIL");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (10) @(negedge clk);
         rst_n   <= 1'b1;
         running <= 1'b1;
         wait (resp_count == n_vec);
         repeat (4) @(negedge clk);
         check_credits(regained, sent);
         $display("Tests %0d, responses %0d, errors %0d", n_vec, resp_count, errors);
         if (errors == 0) begin
            $display("STATUS: PASS");
         end else begin
            $display("STATUS: FAIL");
         end
         $finish;
      end
   end

endmodule

// ==== test/div_unit_tests.txt ====
# Each line holds op, dividend, divisor, expected result and zero flag in hex.
# Op codes are 0 DIVU, 1 DIV, 2 REMU and 3 REM.
0 00000064 00000007 0000000e 0
2 00000064 00000007 00000002 0
0 ffffffff 00000010 0fffffff 0
2 ffffffff 00000010 0000000f 0
0 12345678 00001000 00012345 0
2 12345678 00001000 00000678 0
0 00000003 00000005 00000000 0
2 00000003 00000005 00000003 0
0 80000000 ffffffff 00000000 0
2 80000000 ffffffff 80000000 0
1 00000007 00000002 00000003 0
1 fffffff9 00000002 fffffffd 0
1 00000007 fffffffe fffffffd 0
1 fffffff9 fffffffe 00000003 0
3 00000007 00000002 00000001 0
3 fffffff9 00000002 ffffffff 0
3 00000007 fffffffe 00000001 0
3 fffffff9 fffffffe ffffffff 0
1 ffffff9c 00000007 fffffff2 0
3 ffffff9c 00000007 fffffffe 0
0 00001234 00000000 ffffffff 1
2 00001234 00000000 00001234 1
1 fffffff9 00000000 ffffffff 1
3 fffffff9 00000000 fffffff9 1
1 80000000 ffffffff 80000000 0
3 80000000 ffffffff 00000000 0
